// ==== list.f ====
umi_apb_pkg.sv
apb_if.sv
umi_req_decoder.sv
apb_requester_fsm.sv
apb_wait_timer.sv
umi_resp_builder.sv
apb_reg_bank.sv
umi_apb_subsys.sv
tb_umi_apb_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UMI-to-APB subsystem testbench with Verilator.
# Exits non-zero on a compile error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
   --top-module tb_umi_apb_subsys -f list.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_umi_apb_subsys)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb_umi_apb_subsys.sv ====
// random-stimulus testbench for the UMI-to-APB subsystem, checks responses against a register model
`timescale 1ns/1ps

module tb_umi_apb_subsys;

   localparam int grp_offset     = 24;
   localparam int grp_aw         = 4;
   localparam int grp_id         = 3;
   localparam int timeout_cycles = 16;
   localparam int wait_cycles    = 2;
   localparam int reg_count      = 16;
   localparam int ro_first       = 12;
   localparam int idx_w          = $clog2(reg_count);
   localparam int n_trans        = 400;                 // up to two requests each
   localparam int clk_period     = 8;
   localparam int max_tx_cycles  = timeout_cycles + wait_cycles + 24;  // abort plus stall
   localparam longint watchdog_ns = longint'((2 * n_trans + reg_count) * max_tx_cycles
                                             * clk_period + 64 * clk_period);
   localparam int op_read   = 0;
   localparam int op_write  = 1;
   localparam int op_posted = 2;
   localparam int op_drop   = 3;

   logic                   apb_pclk;
   logic                   apb_nreset;
   logic                   req_valid;
   umi_apb_pkg::umi_cmd_t  req_cmd;
   umi_apb_pkg::umi_addr_t req_dstaddr;
   umi_apb_pkg::umi_addr_t req_srcaddr;
   umi_apb_pkg::umi_data_t req_data;
   logic                   req_ready;
   logic                   resp_valid;
   umi_apb_pkg::umi_cmd_t  resp_cmd;
   umi_apb_pkg::umi_addr_t resp_dstaddr;
   umi_apb_pkg::umi_addr_t resp_srcaddr;
   umi_apb_pkg::umi_data_t resp_data;
   logic                   resp_ready;

   umi_apb_pkg::apb_data_t model [reg_count];   // expected register contents
   umi_apb_pkg::umi_cmd_t  exp_cmd_q [$];
   umi_apb_pkg::umi_addr_t exp_dst_q [$];
   umi_apb_pkg::umi_addr_t exp_src_q [$];
   umi_apb_pkg::umi_data_t exp_data_q [$];
   bit                     exp_chk_q [$];       // data defined for this response
   int                     errors;
   int                     checks;
   int                     resp_seen;

   umi_apb_subsys #(.grp_offset(grp_offset), .grp_aw(grp_aw), .grp_id(grp_id),
      .timeout_cycles(timeout_cycles), .wait_cycles(wait_cycles),
      .reg_count(reg_count), .ro_first(ro_first)) umi_apb_subsys_i (.*);

   initial begin
      apb_pclk = 1'b0;
      forever #(clk_period / 2) apb_pclk = ~apb_pclk;
   end

   // ############################################################
   // helpers
   // ############################################################
   function automatic umi_apb_pkg::umi_addr_t make_dstaddr(input int word, input logic [3:0] grp);
      umi_apb_pkg::umi_addr_t a;
      a = {$urandom, $urandom};                     // random upper bits
      a[grp_offset +: grp_aw] = grp;
      a[15:0] = 16'(word << 2);                     // word aligned apb address
      return a;
   endfunction

   function automatic umi_apb_pkg::umi_cmd_t expect_cmd(input umi_apb_pkg::umi_cmd_t cmd,
                                                        input bit is_read, input logic [1:0] err);
      umi_apb_pkg::umi_cmd_t c;
      c = cmd;                                      // other fields pass through
      c[umi_apb_pkg::umi_opcode_msb:umi_apb_pkg::umi_opcode_lsb] =
         is_read ? umi_apb_pkg::umi_resp_read : umi_apb_pkg::umi_resp_write;
      c[umi_apb_pkg::umi_err_msb:umi_apb_pkg::umi_err_lsb] = err;
      return c;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic push_expected(input umi_apb_pkg::umi_cmd_t cmd, input umi_apb_pkg::umi_addr_t dst,
                                input umi_apb_pkg::umi_addr_t src,
                                input umi_apb_pkg::umi_data_t data, input bit chk);
      exp_cmd_q.push_back(cmd);
      exp_dst_q.push_back(dst);
      exp_src_q.push_back(src);
      exp_data_q.push_back(data);
      exp_chk_q.push_back(chk);
   endtask

   task automatic check_response();
      bit chk;
      if (exp_cmd_q.size() == 0) begin
         errors++;
         $display("ERROR: response at %0t with no request waiting for one", $time);
      end else begin
         chk = exp_chk_q.pop_front();
         compare_value("resp_cmd", 64'(resp_cmd), 64'(exp_cmd_q.pop_front()));
         compare_value("resp_dstaddr", resp_dstaddr, exp_dst_q.pop_front());
         compare_value("resp_srcaddr", resp_srcaddr, exp_src_q.pop_front());
         if (chk)
            compare_value("resp_data", resp_data, exp_data_q.pop_front());
         else
            void'(exp_data_q.pop_front());          // write data not defined
         resp_seen++;
      end
   endtask

   // one request, model update at the handshake
   task automatic issue_request(input int op_sel, input int word, input bit grp_ok);
      umi_apb_pkg::umi_cmd_t  cmd;
      umi_apb_pkg::umi_addr_t dst;
      umi_apb_pkg::umi_addr_t src;
      umi_apb_pkg::umi_data_t data;
      logic [4:0]             op;
      logic [3:0]             grp;
      logic [idx_w-1:0]       idx;
      bit                     claimed;
      bit                     writable;
      bit                     dropped;
      case (op_sel)
         op_read:   op = umi_apb_pkg::umi_req_read;
         op_write:  op = umi_apb_pkg::umi_req_write;
         op_posted: op = umi_apb_pkg::umi_req_posted;
         default: begin
            op = 5'($urandom);                      // atomics, rdma and the rest
            while (op == umi_apb_pkg::umi_req_read || op == umi_apb_pkg::umi_req_write
                   || op == umi_apb_pkg::umi_req_posted)
               op = 5'($urandom);
         end
      endcase
      grp      = grp_ok ? 4'(grp_id) : 4'(grp_id + 1 + $urandom_range(0, 14));
      cmd      = $urandom;
      cmd[umi_apb_pkg::umi_opcode_msb:umi_apb_pkg::umi_opcode_lsb] = op;
      dst      = make_dstaddr(word, grp);
      src      = {$urandom, $urandom};
      data     = {$urandom, $urandom};
      idx      = idx_w'(word);
      claimed  = (word < reg_count);
      writable = claimed && (word < ro_first);
      dropped  = !grp_ok || (op_sel == op_drop);
      @(posedge apb_pclk);
      req_valid   <= 1'b1;
      req_cmd     <= cmd;
      req_dstaddr <= dst;
      req_srcaddr <= src;
      req_data    <= data;
      @(negedge apb_pclk);
      while (!req_ready) @(negedge apb_pclk);      // transfer on the coming edge
      if (!dropped) begin
         if (op_sel == op_read)
            push_expected(expect_cmd(cmd, 1'b1, claimed ? 2'b00 : umi_apb_pkg::umi_err_slverr),
                          src, dst, claimed ? 64'(model[idx]) : 64'h0, 1'b1);
         else if (op_sel == op_write)
            push_expected(expect_cmd(cmd, 1'b0, writable ? 2'b00 : umi_apb_pkg::umi_err_slverr),
                          src, dst, 64'h0, !claimed);  // zero data only on abort
         if (op_sel != op_read && writable)
            model[idx] = data[31:0];
      end
      @(posedge apb_pclk);
      req_valid <= 1'b0;
      if (dropped) begin
         @(negedge apb_pclk);
         if (!req_ready) begin
            errors++;
            $display("ERROR: req_ready went low after a dropped request at %0t", $time);
         end
      end
   endtask

   // ############################################################
   // response side
   // ############################################################
   initial begin : resp_ready_drive
      int low_cycles;
      int high_cycles;
      resp_ready = 1'b0;
      @(posedge apb_nreset);
      forever begin
         low_cycles  = $urandom_range(0, 4);
         high_cycles = $urandom_range(1, 6);
         repeat (low_cycles) begin
            @(posedge apb_pclk);
            resp_ready <= 1'b0;                     // back-pressure
         end
         repeat (high_cycles) begin
            @(posedge apb_pclk);
            resp_ready <= 1'b1;
         end
      end
   end

   initial begin : resp_monitor
      bit                     stalled;
      umi_apb_pkg::umi_cmd_t  held_cmd;
      umi_apb_pkg::umi_addr_t held_dst;
      umi_apb_pkg::umi_addr_t held_src;
      umi_apb_pkg::umi_data_t held_data;
      stalled = 1'b0;
      @(posedge apb_nreset);
      forever begin
         @(negedge apb_pclk);                      // outputs settled mid cycle
         if (stalled) begin
            if (!resp_valid) begin
               errors++;
               $display("ERROR: resp_valid fell without resp_ready at %0t", $time);
            end
            compare_value("resp_cmd", 64'(resp_cmd), 64'(held_cmd));
            compare_value("resp_dstaddr", resp_dstaddr, held_dst);
            compare_value("resp_srcaddr", resp_srcaddr, held_src);
            compare_value("resp_data", resp_data, held_data);
         end
         if (resp_valid && req_ready) begin
            errors++;
            $display("ERROR: req_ready high while a response waits at %0t", $time);
         end
         if (resp_valid && resp_ready)
            check_response();
         stalled   = resp_valid && !resp_ready;
         held_cmd  = resp_cmd;
         held_dst  = resp_dstaddr;
         held_src  = resp_srcaddr;
         held_data = resp_data;
      end
   end

   initial begin : watchdog
      #(watchdog_ns);
      errors++;
      $display("ERROR: watchdog expired, the DUT stopped answering");
      $display("summary: %0d checks, %0d responses, %0d errors", checks, resp_seen, errors);
      $display("Regression failed");
      $finish;
   end

   // ############################################################
   // main sequence
   // ############################################################
   initial begin : main_seq
      int sel;
      int word;
      void'($urandom(32'hc545_d959));
      errors      = 0;
      checks      = 0;
      resp_seen   = 0;
      model       = '{default: '0};                 // bank resets to zero
      apb_nreset  = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      repeat (16) @(posedge apb_pclk);
      apb_nreset <= 1'b1;
      @(negedge apb_pclk);
      if (!req_ready || resp_valid) begin
         errors++;
         $display("ERROR: wrong handshake levels after reset");
      end
      for (int t = 0; t < n_trans; t++) begin
         sel  = $urandom_range(0, 99);
         word = $urandom_range(0, reg_count - 1);
         if (sel < 25) begin
            issue_request(op_write, word, 1'b1);   // write then read back
            issue_request(op_read, word, 1'b1);
         end else if (sel < 45)
            issue_request(op_read, word, 1'b1);
         else if (sel < 60)
            issue_request(op_posted, word, 1'b1);
         else if (sel < 70)
            issue_request(op_drop, word, 1'b1);
         else if (sel < 80)
            issue_request($urandom_range(0, 2), word, 1'b0);   // wrong group
         else if (sel < 86)
            issue_request($urandom_range(0, 2), reg_count + $urandom_range(0, 200), 1'b1);
         else
            issue_request(op_write, word, 1'b1);
      end
      for (int w = 0; w < reg_count; w++)
         issue_request(op_read, w, 1'b1);          // final sweep of the bank
      @(negedge apb_pclk);
      while (exp_cmd_q.size() != 0 || !req_ready) @(negedge apb_pclk);
      repeat (4) @(negedge apb_pclk);
      $display("summary: %0d checks, %0d responses, %0d errors", checks, resp_seen, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== umi_apb_subsys.sv ====
// subsystem top: UMI-to-APB bridge blocks wired to the APB register bank
`timescale 1ns/1ps

module umi_apb_subsys #(
   parameter int grp_offset     = 24,
   parameter int grp_aw         = 4,
   parameter int grp_id         = 3,
   parameter int timeout_cycles = 16,
   parameter int wait_cycles    = 2,
   parameter int reg_count      = 16,
   parameter int ro_first       = 12
) (
   input  logic                   apb_pclk,
   input  logic                   apb_nreset,
   // umi request
   input  logic                   req_valid,
   input  umi_apb_pkg::umi_cmd_t  req_cmd,
   input  umi_apb_pkg::umi_addr_t req_dstaddr,
   input  umi_apb_pkg::umi_addr_t req_srcaddr,
   input  umi_apb_pkg::umi_data_t req_data,
   output logic                   req_ready,
   // umi response
   output logic                   resp_valid,
   output umi_apb_pkg::umi_cmd_t  resp_cmd,
   output umi_apb_pkg::umi_addr_t resp_dstaddr,
   output umi_apb_pkg::umi_addr_t resp_srcaddr,
   output umi_apb_pkg::umi_data_t resp_data,
   input  logic                   resp_ready
);
   logic                   accept;
   umi_apb_pkg::req_kind_t kind;
   umi_apb_pkg::umi_cmd_t  cap_cmd;
   umi_apb_pkg::umi_addr_t cap_dstaddr;
   umi_apb_pkg::umi_addr_t cap_srcaddr;
   umi_apb_pkg::apb_data_t cap_wdata;
   logic                   timer_run;
   logic                   expired;
   logic                   done;
   logic                   timed_out;

   apb_if apb (.apb_pclk(apb_pclk), .apb_nreset(apb_nreset));

   umi_req_decoder #(.grp_offset(grp_offset), .grp_aw(grp_aw), .grp_id(grp_id))
      umi_req_decoder_i (.*);

   apb_requester_fsm apb_requester_fsm_i (.*, .apb(apb.requester));

   apb_wait_timer #(.timeout_cycles(timeout_cycles)) apb_wait_timer_i (
      .apb_pclk(apb_pclk), .apb_nreset(apb_nreset), .run(timer_run), .expired(expired));

   umi_resp_builder umi_resp_builder_i (.*, .apb(apb.monitor));

   apb_reg_bank #(.wait_cycles(wait_cycles), .reg_count(reg_count), .ro_first(ro_first))
      apb_reg_bank_i (.apb_pclk(apb_pclk), .apb_nreset(apb_nreset), .apb(apb.completer));

endmodule

// ==== apb_reg_bank.sv ====
// APB completer register bank with wait states and a read-only upper region
`timescale 1ns/1ps

module apb_reg_bank #(
   parameter int wait_cycles = 2,
   parameter int reg_count   = 16,
   parameter int ro_first    = 12
) (
   input  logic     apb_pclk,
   input  logic     apb_nreset,
   apb_if.completer apb
);
   localparam int idx_w = $clog2(reg_count);
   localparam int wcnt_w = $clog2(wait_cycles + 2);

   umi_apb_pkg::apb_data_t regs [reg_count];
   logic [13:0]            widx;       // word index of paddr
   logic [idx_w-1:0]       idx;
   logic                   claimed;
   logic                   access;
   logic                   read_only;
   logic [wcnt_w-1:0]      wcnt;       // wait states so far

   assign widx      = apb.paddr[15:2];
   assign idx       = widx[idx_w-1:0];
   assign claimed   = (widx < 14'(reg_count));
   assign access    = apb.psel & apb.penable & claimed;  // unclaimed never answer
   assign read_only = (widx >= 14'(ro_first));

   // ############################################################
   // wait states
   // ############################################################
   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset)
         wcnt <= '0;
      else if (access && !apb.pready)
         wcnt <= wcnt + 1'b1;
      else
         wcnt <= '0;
   end

   assign apb.pready  = access & (wcnt == wcnt_w'(wait_cycles));
   assign apb.pslverr = apb.pready & apb.pwrite & read_only;
   assign apb.prdata  = claimed ? regs[idx] : '0;

   // ############################################################
   // register file
   // ############################################################
   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         for (int i = 0; i < reg_count; i++)
            regs[i] <= '0;
      end else if (apb.pready && apb.pwrite && !read_only && (&apb.pstrb)) begin
         regs[idx] <= apb.pwdata;   // ro writes dropped
      end
   end

endmodule

// ==== umi_resp_builder.sv ====
// UMI response formation: read data and error capture, address swap, command rebuild
`timescale 1ns/1ps

module umi_resp_builder (
   input  logic                   apb_pclk,
   input  logic                   apb_nreset,
   input  logic                   done,
   input  logic                   timed_out,
   input  umi_apb_pkg::req_kind_t kind,
   input  umi_apb_pkg::umi_cmd_t  cap_cmd,
   input  umi_apb_pkg::umi_addr_t cap_dstaddr,
   input  umi_apb_pkg::umi_addr_t cap_srcaddr,
   apb_if.monitor                 apb,
   output umi_apb_pkg::umi_cmd_t  resp_cmd,
   output umi_apb_pkg::umi_addr_t resp_dstaddr,
   output umi_apb_pkg::umi_addr_t resp_srcaddr,
   output umi_apb_pkg::umi_data_t resp_data
);
   umi_apb_pkg::apb_data_t rdata_q;
   logic [1:0]             err_q;

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset)
         err_q <= 2'b00;
      else if (done)
         err_q <= (apb.pslverr | timed_out) ? umi_apb_pkg::umi_err_slverr : 2'b00;
   end

   always_ff @(posedge apb_pclk) begin
      if (done)
         rdata_q <= timed_out ? '0 : apb.prdata;   // zero data on abort
   end

   // ############################################################
   // response fields
   // ############################################################
   always_comb begin
      resp_cmd = cap_cmd;   // keep all other request bits
      resp_cmd[umi_apb_pkg::umi_opcode_msb:umi_apb_pkg::umi_opcode_lsb] =
         (kind == umi_apb_pkg::kind_read) ? umi_apb_pkg::umi_resp_read
                                          : umi_apb_pkg::umi_resp_write;
      resp_cmd[umi_apb_pkg::umi_err_msb:umi_apb_pkg::umi_err_lsb] = err_q;
   end

   assign resp_dstaddr = cap_srcaddr;                 // back to requester
   assign resp_srcaddr = cap_dstaddr;
   assign resp_data    = umi_apb_pkg::umi_data_t'(rdata_q);  // zero extend

endmodule

// ==== apb_wait_timer.sv ====
// access-phase watchdog that flags a timeout when no completer answers
`timescale 1ns/1ps

module apb_wait_timer #(
   parameter int timeout_cycles = 16
) (
   input  logic apb_pclk,
   input  logic apb_nreset,
   input  logic run,
   output logic expired
);
   localparam int cnt_w = $clog2(timeout_cycles + 1);

   logic [cnt_w-1:0] cnt;   // access cycles seen so far

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset)
         cnt <= '0;
      else if (!run)
         cnt <= '0;                       // idle clears
      else if (!expired)
         cnt <= cnt + 1'b1;               // saturate at limit
   end

   assign expired = (cnt == cnt_w'(timeout_cycles));

endmodule

// ==== apb_requester_fsm.sv ====
// APB requester FSM that runs the setup and access phases and hands results to the response builder
`timescale 1ns/1ps

module apb_requester_fsm (
   input  logic                   apb_pclk,
   input  logic                   apb_nreset,
   input  logic                   accept,
   input  umi_apb_pkg::req_kind_t kind,
   input  umi_apb_pkg::umi_addr_t cap_dstaddr,
   input  umi_apb_pkg::apb_data_t cap_wdata,
   input  umi_apb_pkg::umi_cmd_t  cap_cmd,
   input  logic                   expired,
   input  logic                   resp_ready,
   output logic                   req_ready,
   output logic                   timer_run,
   output logic                   done,
   output logic                   timed_out,
   output logic                   resp_valid,
   apb_if.requester               apb
);
   umi_apb_pkg::bridge_state_t state;
   umi_apb_pkg::bridge_state_t state_nxt;
   logic                       access_end;

   assign access_end = (state == umi_apb_pkg::st_access) & (apb.pready | expired);

   // ############################################################
   // state machine
   // ############################################################
   always_comb begin
      state_nxt = state;
      case (state)
         umi_apb_pkg::st_idle:   if (accept) state_nxt = umi_apb_pkg::st_setup;
         umi_apb_pkg::st_setup:  state_nxt = umi_apb_pkg::st_access;
         umi_apb_pkg::st_access: begin
            if (access_end)
               state_nxt = (kind == umi_apb_pkg::kind_posted) ? umi_apb_pkg::st_idle
                                                              : umi_apb_pkg::st_resp;
         end
         default:                if (resp_ready) state_nxt = umi_apb_pkg::st_idle;
      endcase
   end

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset)
         state <= umi_apb_pkg::st_idle;
      else
         state <= state_nxt;
   end

   // ############################################################
   // outputs
   // ############################################################
   assign req_ready  = (state == umi_apb_pkg::st_idle);   // one request in flight
   assign resp_valid = (state == umi_apb_pkg::st_resp);
   assign timer_run  = (state == umi_apb_pkg::st_access);
   assign done       = access_end;
   assign timed_out  = access_end & ~apb.pready;          // no completer answered

   assign apb.psel    = (state == umi_apb_pkg::st_setup) | (state == umi_apb_pkg::st_access);
   assign apb.penable = (state == umi_apb_pkg::st_access);
   assign apb.pwrite  = (kind == umi_apb_pkg::kind_write) | (kind == umi_apb_pkg::kind_posted);
   assign apb.paddr   = umi_apb_pkg::apb_addr_t'(cap_dstaddr);
   assign apb.pwdata  = cap_wdata;
   assign apb.pstrb   = 4'hf;                             // full word writes
   assign apb.pprot   = {1'b0, cap_cmd[umi_apb_pkg::umi_prot_msb:umi_apb_pkg::umi_prot_lsb]};

   // ############################################################
   // checks
   // ############################################################
   // completer answers only inside the access phase
   a_pready_access: assert property (@(posedge apb_pclk) disable iff (!apb_nreset)
      apb.pready |-> apb.psel && apb.penable);
   a_paddr_stable: assert property (@(posedge apb_pclk) disable iff (!apb_nreset)
      apb.penable |-> $stable(apb.paddr));
   a_resp_hold: assert property (@(posedge apb_pclk) disable iff (!apb_nreset)
      resp_valid && !resp_ready |=> resp_valid);

endmodule

// ==== umi_req_decoder.sv ====
// UMI request decoder that checks the group, sorts the opcode and captures the request for the APB side
`timescale 1ns/1ps

module umi_req_decoder #(
   parameter int grp_offset = 24,
   parameter int grp_aw     = 4,
   parameter int grp_id     = 3
) (
   input  logic                   apb_pclk,
   input  logic                   apb_nreset,
   input  logic                   req_valid,
   input  umi_apb_pkg::umi_cmd_t  req_cmd,
   input  umi_apb_pkg::umi_addr_t req_dstaddr,
   input  umi_apb_pkg::umi_addr_t req_srcaddr,
   input  umi_apb_pkg::umi_data_t req_data,
   input  logic                   req_ready,
   output logic                   accept,
   output umi_apb_pkg::req_kind_t kind,
   output umi_apb_pkg::umi_cmd_t  cap_cmd,
   output umi_apb_pkg::umi_addr_t cap_dstaddr,
   output umi_apb_pkg::umi_addr_t cap_srcaddr,
   output umi_apb_pkg::apb_data_t cap_wdata
);
   logic                   group_match;
   umi_apb_pkg::req_kind_t kind_now;   // kind of the packet on the bus

   generate
      if (grp_aw != 0) begin : g_grp
         assign group_match = (req_dstaddr[grp_offset +: grp_aw] == grp_aw'(grp_id));
      end else begin : g_nogrp
         assign group_match = 1'b1;    // check disabled
      end
   endgenerate

   always_comb begin
      case (req_cmd[umi_apb_pkg::umi_opcode_msb:umi_apb_pkg::umi_opcode_lsb])
         umi_apb_pkg::umi_req_read:   kind_now = umi_apb_pkg::kind_read;
         umi_apb_pkg::umi_req_write:  kind_now = umi_apb_pkg::kind_write;
         umi_apb_pkg::umi_req_posted: kind_now = umi_apb_pkg::kind_posted;
         default:                     kind_now = umi_apb_pkg::kind_drop; // atomics, rdma
      endcase
      if (!group_match)
         kind_now = umi_apb_pkg::kind_drop;
   end

   // dropped packets still handshake but never start the fsm
   assign accept = req_valid & req_ready & (kind_now != umi_apb_pkg::kind_drop);

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset)
         kind <= umi_apb_pkg::kind_drop;
      else if (accept)
         kind <= kind_now;
   end

   always_ff @(posedge apb_pclk) begin
      if (accept) begin
         cap_cmd     <= req_cmd;
         cap_dstaddr <= req_dstaddr;
         cap_srcaddr <= req_srcaddr;
         cap_wdata   <= req_data[31:0];  // rw-aligned low word only
      end
   end

   // one request in flight once the fsm has taken it
   a_accept_busy: assert property (@(posedge apb_pclk) disable iff (!apb_nreset)
      accept |=> !req_ready);

endmodule

// ==== apb_if.sv ====
// APB signal group between the bridge requester and the register bank completer
`timescale 1ns/1ps

interface apb_if (
   input logic apb_pclk,
   input logic apb_nreset
);
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   umi_apb_pkg::apb_addr_t paddr;
   umi_apb_pkg::apb_data_t pwdata;
   logic [3:0]             pstrb;
   logic [2:0]             pprot;
   logic                   pready;
   umi_apb_pkg::apb_data_t prdata;
   logic                   pslverr;

   modport requester (output psel, penable, pwrite, paddr, pwdata, pstrb, pprot,
                      input pready, prdata, pslverr);
   modport completer (input psel, penable, pwrite, paddr, pwdata, pstrb, pprot,
                      output pready, prdata, pslverr);
   modport monitor (input prdata, pslverr);

   // a setup cycle is always followed by access with the same control and data
   a_setup_to_access: assert property (@(posedge apb_pclk) disable iff (!apb_nreset)
      psel && !penable |=> penable && $stable(pwrite) && $stable(pwdata)
                           && $stable(pprot) && $stable(pstrb));

endinterface

// ==== umi_apb_pkg.sv ====
// shared UMI field positions, opcodes, bus types and FSM states for the UMI-to-APB bridge
package umi_apb_pkg;

   // ############################################################
   // bus types
   // ############################################################
   typedef logic [31:0] umi_cmd_t;   // umi command word
   typedef logic [63:0] umi_addr_t;  // umi src/dst address
   typedef logic [63:0] umi_data_t;  // umi data bus
   typedef logic [15:0] apb_addr_t;  // apb byte address
   typedef logic [31:0] apb_data_t;  // apb register word

   // ############################################################
   // command word fields
   // ############################################################
   localparam int umi_opcode_lsb = 0;
   localparam int umi_opcode_msb = 4;
   localparam int umi_prot_lsb   = 21;
   localparam int umi_prot_msb   = 22;
   localparam int umi_err_lsb    = 25;
   localparam int umi_err_msb    = 26;

   // opcodes
   localparam logic [4:0] umi_req_read   = 5'd1;
   localparam logic [4:0] umi_req_write  = 5'd3;
   localparam logic [4:0] umi_req_posted = 5'd5;
   localparam logic [4:0] umi_resp_read  = 5'd8;
   localparam logic [4:0] umi_resp_write = 5'd9;

   localparam logic [1:0] umi_err_slverr = 2'b10; // slave error or timeout

   // ############################################################
   // enums
   // ############################################################
   typedef enum logic [1:0] {
      kind_read,
      kind_write,
      kind_posted,
      kind_drop    // atomics, rdma, wrong group
   } req_kind_t;

   typedef enum logic [1:0] {
      st_idle,
      st_setup,
      st_access,
      st_resp
   } bridge_state_t;

endpackage
